// ==== compile.f ====
hw/mips_pkg.sv
hw/alu_controller.sv
hw/control_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_core.sv
test/tb_mips_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_mips_core with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --assert -j 0 --top-module tb_mips_core -Mdir obj_dir -f compile.f
	./obj_dir/Vtb_mips_core > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== test/mips_vectors.txt ====
# columns: kind value [value]; I program word from pc 0, D byte address and data word
# W register and data in retire order, S byte address and data in store order
I 20010005  # addi  r1, r0, 5
I 2402fffd  # addiu r2, r0, -3
I 34038001  # ori   r3, r0, 0x8001
I 3c041234  # lui   r4, 0x1234
I 20200007  # addi  r0, r1, 7, no writeback
I 00222822  # sub   r5, r1, r2
I 3866ffff  # xori  r6, r3, 0xffff
I ac040010  # sw    r4, 16(r0)
I 0041382a  # slt   r7, r2, r1
I 00644027  # nor   r8, r3, r4
I 8c090010  # lw    r9, 16(r0), reads back the store
I 8c0a0020  # lw    r10, 32(r0)
I 00025843  # sra   r11, r2, 1
I 00a66024  # and   r12, r5, r6
I 0c000011  # jal   0x44
I 200d0001  # addi  r13, r0, 1, skipped
I 200e0001  # addi  r14, r0, 1, skipped
I 11240002  # beq   r9, r4, taken
I 200d0002  # addi  r13, r0, 2, skipped
I 200e0002  # addi  r14, r0, 2, skipped
I 15240003  # bne   r9, r4, not taken
I 000a7902  # srl   r15, r10, 4
I 2850fffe  # slti  r16, r2, -2
I 20110078  # addi  r17, r0, 0x78
I 04410003  # bgez  r2, not taken
I ac0f0024  # sw    r15, 36(r0)
I 020b9825  # or    r19, r16, r11
I 02200008  # jr    r17
I 200d0003  # addi  r13, r0, 3, skipped
I 200e0003  # addi  r14, r0, 3, skipped
I 08000021  # j     0x84
I 200d0004  # addi  r13, r0, 4, skipped
I 200e0004  # addi  r14, r0, 4, skipped
I 8c120024  # lw    r18, 36(r0)
I 00a1a004  # sllv  r20, r1, r5
I 305500f0  # andi  r21, r2, 0x00f0
I 0107b021  # addu  r22, r8, r7
I 0000000c  # syscall
I 20170009  # addi  r23, r0, 9, never retires
D 00000020 cafef00d
W 01 00000005
W 02 fffffffd
W 03 00008001
W 04 12340000
W 05 00000008
W 06 00007ffe
W 07 00000001
W 08 edcb7ffe
W 09 12340000
W 0a cafef00d
W 0b fffffffe
W 0c 00000008
W 1f 0000003c  # link value of jal at 0x38
W 0f 0cafef00
W 10 00000001
W 11 00000078
W 13 ffffffff
W 12 0cafef00
W 14 00000500
W 15 000000f0
W 16 edcb7fff
S 00000010 12340000
S 00000024 0cafef00

// ==== test/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int RUN_LIMIT    = 2000;   // cycles allowed until halted
    localparam int QUIET_CYCLES = 20;

    logic     clk;
    logic     reset;
    word_t    imem_addr, imem_data;
    word_t    dmem_addr, dmem_wdata, dmem_rdata;
    logic     dmem_we, dmem_re, dmem_hit;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     halted;

    word_t    imem [256];
    word_t    dmem [256];
    reg_idx_t exp_wb_reg [$];
    word_t    exp_wb_data [$];
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];

    integer seed;
    int     wb_errors;
    int     st_errors;
    int     timeout_errors;

    mips_core #(.RESET_PC(32'h0)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        logic [7:0] pc_idx;
        pc_idx = '0;
        fd = $fopen("test/mips_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mips_vectors.txt, the core has no program");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", kind, a, b);
            if (n < 2) begin
                continue;   // blank line
            end
            case (kind)
                "I": begin
                    imem[pc_idx] = a;
                    pc_idx++;
                end
                "D": dmem[a[9:2]] = b;   // byte address
                "W": begin
                    exp_wb_reg.push_back(a[4:0]);
                    exp_wb_data.push_back(b);
                end
                "S": begin
                    exp_st_addr.push_back(a);
                    exp_st_data.push_back(b);
                end
                default: ;   // comment line
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_wb(input reg_idx_t got_reg, input word_t got_data);
        reg_idx_t want_reg;
        word_t    want_data;
        if (exp_wb_reg.size() == 0) begin
            wb_errors++;
            $display("ERROR %0t: unexpected writeback r%0d = %h", $time, got_reg, got_data);
            return;
        end
        want_reg  = exp_wb_reg.pop_front();
        want_data = exp_wb_data.pop_front();
        if (got_reg !== want_reg || got_data !== want_data) begin
            wb_errors++;
            $display("ERROR %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, got_reg, got_data, want_reg, want_data);
        end
    endtask

    task automatic check_store(input word_t got_addr, input word_t got_data);
        word_t want_addr;
        word_t want_data;
        if (exp_st_addr.size() == 0) begin
            st_errors++;
            $display("ERROR %0t: unexpected store %h to %h", $time, got_data, got_addr);
            return;
        end
        want_addr = exp_st_addr.pop_front();
        want_data = exp_st_data.pop_front();
        if (got_addr !== want_addr || got_data !== want_data) begin
            st_errors++;
            $display("ERROR %0t: store %h to %h, expected %h to %h",
                     $time, got_data, got_addr, want_data, want_addr);
        end
    endtask

    // called 2 ns after each edge, DUT outputs have settled by then
    task automatic serve_memories();
        dmem_hit   = ($random(seed) & 32'd3) != 32'd0;   // roughly one miss in four
        imem_data  = imem[imem_addr[9:2]];
        dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 'x;   // valid only on a load request
        if (wb_en) begin
            check_wb(wb_reg, wb_data);
        end
        if (dmem_we && dmem_hit) begin
            check_store(dmem_addr, dmem_wdata);
            dmem[dmem_addr[9:2]] = dmem_wdata;
        end
    endtask

    initial begin
        int cycles;
        seed           = 32'he18e;
        wb_errors      = 0;
        st_errors      = 0;
        timeout_errors = 0;
        reset          = 1'b1;
        imem_data      = '0;
        dmem_rdata     = '0;
        dmem_hit       = 1'b0;
        imem           = '{default: '0};
        dmem           = '{default: '0};
        load_vectors();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        cycles = 0;
        while (!halted && cycles < RUN_LIMIT) begin
            serve_memories();
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!halted) begin
            timeout_errors++;
            $display("timeout: the core did not halt within %0d cycles", RUN_LIMIT);
        end
        if (exp_wb_reg.size() != 0) begin
            wb_errors += exp_wb_reg.size();
            $display("%0d expected writebacks never happened", exp_wb_reg.size());
        end
        if (exp_st_addr.size() != 0) begin
            st_errors += exp_st_addr.size();
            $display("%0d expected stores never happened", exp_st_addr.size());
        end

        // frozen core, nothing may retire
        for (int i = 0; i < QUIET_CYCLES && halted; i++) begin
            if (wb_en) begin
                wb_errors++;
                $display("ERROR %0t: writeback r%0d after halt", $time, wb_reg);
            end
            if (dmem_we) begin
                st_errors++;
                $display("ERROR %0t: store to %h after halt", $time, dmem_addr);
            end
            @(posedge clk);
            #2;
        end

        $display("writeback errors %0d, store errors %0d, timeouts %0d",
                 wb_errors, st_errors, timeout_errors);
        if (wb_errors + st_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    output mips_pkg::word_t    imem_addr,
    input  mips_pkg::word_t    imem_data,
    output mips_pkg::word_t    dmem_addr,
    output mips_pkg::word_t    dmem_wdata,
    output logic               dmem_we,
    output logic               dmem_re,
    input  mips_pkg::word_t    dmem_rdata,
    input  logic               dmem_hit,
    output logic               wb_en,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               halted
);
    import mips_pkg::*;

    logic       stall_free, run, halt_seen, redirect;
    word_t      redirect_pc, if_pc, if_inst;
    word_t      ex_pc, ex_a, ex_b, ex_imm, ex_inst;
    logic [4:0] ex_shamt;
    reg_idx_t   ex_dest, mem_dest;
    alu_op_e    ex_alu_op;
    logic ex_alu_src, ex_link, ex_mem_to_reg, ex_mem_write, ex_mem_read;
    logic ex_reg_write, ex_shift_imm, ex_branch, ex_jump, ex_jump_register, ex_halt;
    word_t mem_result, mem_store_data, mem_link_pc, mem_inst;
    logic mem_reg_write, mem_load, mem_store, mem_from_dmem, mem_link, mem_halt;

    // syscall sitting in MEM stops the pipe one edge before halted rises
    assign run = stall_free && !halted && !halt_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_seen) begin
            halted <= 1'b1;
        end
    end

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .advance (run),
        .flush   (redirect),
        .*
    );

    decode_stage u_decode (
        .advance     (run),
        .flush       (redirect),
        .advance_out (stall_free),
        .*
    );

    execute_stage u_execute (
        .advance (run),
        .*
    );

    memory_stage u_memory (
        .advance (run),
        .*
    );

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic clk, reset, advance,
    input  mips_pkg::word_t    mem_result, mem_store_data, mem_link_pc,
    input  mips_pkg::reg_idx_t mem_dest,
    input  logic mem_reg_write, mem_load, mem_store, mem_from_dmem, mem_link, mem_halt,
    input  mips_pkg::word_t    dmem_rdata,
    output mips_pkg::word_t    dmem_addr, dmem_wdata,
    output logic               dmem_we, dmem_re,
    output logic               wb_en,
    output mips_pkg::reg_idx_t wb_reg,
    output mips_pkg::word_t    wb_data,
    output logic               halt_seen
);
    import mips_pkg::*;

    word_t wb_value;

    // request stays put while EX/MEM is frozen on a miss
    assign dmem_addr  = mem_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_store;
    assign dmem_re    = mem_load;
    assign halt_seen  = mem_halt;

    assign wb_value = mem_from_dmem ? dmem_rdata : (mem_link ? mem_link_pc : mem_result);

    // single pulse per retire, r0 writes dropped here
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= advance && mem_reg_write && (mem_dest != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_reg  <= mem_dest;
            wb_data <= wb_value;
        end
    end

    // a pending request waits for the hit unchanged
    assert property (@(posedge clk) disable iff (reset)
        (dmem_we || dmem_re) && !advance |=>
            $stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_we) && $stable(dmem_re));

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic clk, reset, advance,
    input  mips_pkg::word_t    ex_pc, ex_a, ex_b, ex_imm, ex_inst,
    input  logic [4:0]         ex_shamt,
    input  mips_pkg::reg_idx_t ex_dest,
    input  mips_pkg::alu_op_e  ex_alu_op,
    input  logic ex_alu_src, ex_link, ex_mem_to_reg, ex_mem_write, ex_mem_read,
    input  logic ex_reg_write, ex_shift_imm, ex_branch, ex_jump, ex_jump_register, ex_halt,
    output logic               redirect,
    output mips_pkg::word_t    redirect_pc,
    output mips_pkg::word_t    mem_result, mem_store_data, mem_link_pc, mem_inst,
    output mips_pkg::reg_idx_t mem_dest,
    output logic mem_reg_write, mem_load, mem_store, mem_from_dmem, mem_link, mem_halt
);
    import mips_pkg::*;

    word_t      op_b, result, pc4, br_target, jmp_target;
    logic [4:0] sh;
    opcode_e    op;
    logic       taken;

    assign op_b = ex_alu_src ? ex_imm : ex_b;
    assign sh   = ex_shift_imm ? ex_shamt : ex_a[4:0];   // sllv/srlv take rs
    assign op   = opcode_e'(ex_inst[31:26]);

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: result = ex_a + op_b;
            ALU_SUB: result = ex_a - op_b;
            ALU_AND: result = ex_a & op_b;
            ALU_OR:  result = ex_a | op_b;
            ALU_XOR: result = ex_a ^ op_b;
            ALU_NOR: result = ~(ex_a | op_b);
            ALU_SLT: result = {31'b0, $signed(ex_a) < $signed(op_b)};
            ALU_SLL: result = op_b << sh;
            ALU_SRL: result = op_b >> sh;
            ALU_SRA: result = word_t'($signed(op_b) >>> sh);
            ALU_LUI: result = {op_b[15:0], 16'b0};
            default: result = op_b;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ:  taken = (result == '0);
            OP_BNE:  taken = (result != '0);
            OP_BLEZ: taken = ex_a[31] || (ex_a == '0);
            OP_BGTZ: taken = !ex_a[31] && (ex_a != '0);
            OP_BGEZ: taken = ex_inst[16] ? !ex_a[31] : ex_a[31];   // rt=0 is bltz
            default: taken = 1'b0;
        endcase
    end

    assign pc4         = ex_pc + 32'd4;
    assign br_target   = pc4 + {ex_imm[29:0], 2'b00};
    assign jmp_target  = ex_jump_register ? ex_a : {pc4[31:28], ex_inst[25:0], 2'b00};
    assign redirect    = advance && ((ex_branch && taken) || ex_jump || ex_jump_register);
    assign redirect_pc = ex_branch ? br_target : jmp_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_inst      <= '0;
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            mem_from_dmem <= 1'b0;
            mem_link      <= 1'b0;
            mem_halt      <= 1'b0;
        end else if (advance) begin
            mem_inst      <= ex_inst;
            mem_reg_write <= ex_reg_write;
            mem_load      <= ex_mem_read;
            mem_store     <= ex_mem_write;
            mem_from_dmem <= ex_mem_to_reg;
            mem_link      <= ex_link;
            mem_halt      <= ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_result     <= result;
            mem_store_data <= ex_b;
            mem_link_pc    <= pc4;
            mem_dest       <= ex_dest;
        end
    end

    // the flushed ID/EX slot behind a transfer can never redirect again
    assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect);

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic clk, reset, advance, flush,
    input  mips_pkg::word_t    if_pc, if_inst,
    input  logic               wb_en,
    input  mips_pkg::reg_idx_t wb_reg,
    input  mips_pkg::word_t    wb_data,
    input  logic               dmem_hit,
    input  mips_pkg::word_t    mem_inst,
    output logic               advance_out,
    output mips_pkg::word_t    ex_pc, ex_a, ex_b, ex_imm, ex_inst,
    output logic [4:0]         ex_shamt,
    output mips_pkg::reg_idx_t ex_dest,
    output mips_pkg::alu_op_e  ex_alu_op,
    output logic ex_alu_src, ex_link, ex_mem_to_reg, ex_mem_write, ex_mem_read,
    output logic ex_reg_write, ex_shift_imm, ex_branch, ex_jump, ex_jump_register, ex_halt
);
    import mips_pkg::*;

    word_t    regs [32];
    reg_idx_t rs, rt, rd, dest;
    word_t    rs_val, rt_val, imm;
    alu_op_e  alu_op;
    logic alu_src, reg_dest, link, mem_to_reg, mem_write, mem_read;
    logic reg_write, shift_imm, zero_ext, branch, jump, jump_register, halt;

    control_unit u_control_unit (
        .inst_id  (if_inst),
        .inst_mem (mem_inst),
        .hit      (dmem_hit),
        .advance  (advance_out),
        .*
    );

    assign rs = if_inst[25:21];
    assign rt = if_inst[20:16];
    assign rd = if_inst[15:11];

    // no bypass, a read in the write cycle sees the old value
    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rs_val = (rs == 5'd0) ? '0 : regs[rs];
    assign rt_val = (rt == 5'd0) ? '0 : regs[rt];
    assign imm    = zero_ext ? {16'b0, if_inst[15:0]} : {{16{if_inst[15]}}, if_inst[15:0]};
    assign dest   = link ? 5'd31 : (reg_dest ? rd : rt);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex_inst          <= '0;
            ex_alu_src       <= 1'b0;
            ex_link          <= 1'b0;
            ex_mem_to_reg    <= 1'b0;
            ex_mem_write     <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_reg_write     <= 1'b0;
            ex_shift_imm     <= 1'b0;
            ex_branch        <= 1'b0;
            ex_jump          <= 1'b0;
            ex_jump_register <= 1'b0;
            ex_halt          <= 1'b0;
        end else if (advance) begin
            ex_inst          <= if_inst;
            ex_alu_src       <= alu_src;
            ex_link          <= link;
            ex_mem_to_reg    <= mem_to_reg;
            ex_mem_write     <= mem_write;
            ex_mem_read      <= mem_read;
            ex_reg_write     <= reg_write;
            ex_shift_imm     <= shift_imm;
            ex_branch        <= branch;
            ex_jump          <= jump;
            ex_jump_register <= jump_register;
            ex_halt          <= halt;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_pc     <= if_pc;
            ex_a      <= rs_val;
            ex_b      <= rt_val;
            ex_imm    <= imm;
            ex_shamt  <= if_inst[10:6];
            ex_dest   <= dest;
            ex_alu_op <= alu_op;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic clk, reset, advance, halted, flush, redirect,
    input  mips_pkg::word_t redirect_pc,
    input  mips_pkg::word_t imem_data,
    output mips_pkg::word_t imem_addr,
    output mips_pkg::word_t if_pc,
    output mips_pkg::word_t if_inst
);
    import mips_pkg::*;

    word_t pc;
    logic  step;

    assign imem_addr = pc;   // combinational read
    assign step      = advance && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (step) begin
            pc <= pc + 32'd4;
        end
    end

    // all-zero word decodes as sll r0 and retires nothing
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_inst <= '0;
        end else if (step) begin
            if_inst <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if_pc <= pc;
        end
    end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::word_t   inst_id,
    input  mips_pkg::word_t   inst_mem,
    input  logic              hit,
    output mips_pkg::alu_op_e alu_op,
    output logic alu_src, reg_dest, link, mem_to_reg, mem_write, mem_read,
    output logic reg_write, shift_imm, zero_ext, branch, jump, jump_register,
    output logic halt, advance
);
    import mips_pkg::*;

    opcode_e op_id;
    opcode_e op_mem;
    funct_e  fn_id;
    logic    is_mem_inst;

    assign op_id  = opcode_e'(inst_id[31:26]);
    assign fn_id  = funct_e'(inst_id[5:0]);
    assign op_mem = opcode_e'(inst_mem[31:26]);

    // load/store in MEM holds everything until the data port hits
    assign is_mem_inst = (op_mem == OP_LW) || (op_mem == OP_SW);
    assign advance     = !is_mem_inst || hit;

    alu_controller u_alu_controller (
        .opcode (op_id),
        .funct  (fn_id),
        .alu_op (alu_op)
    );

    always_comb begin
        alu_src       = 1'b0;
        reg_dest      = 1'b0;
        link          = 1'b0;
        mem_to_reg    = 1'b0;
        mem_write     = 1'b0;
        mem_read      = 1'b0;
        reg_write     = 1'b0;
        shift_imm     = 1'b0;
        zero_ext      = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        jump_register = 1'b0;
        halt          = 1'b0;
        case (op_id)
            OP_RTYPE: begin
                case (fn_id)
                    FN_JR:      jump_register = 1'b1;
                    FN_SYSCALL: halt = 1'b1;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        reg_dest  = 1'b1;
                        reg_write = 1'b1;
                        shift_imm = 1'b1; // shamt field, not rs
                    end
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLLV, FN_SRLV: begin
                        reg_dest  = 1'b1;
                        reg_write = 1'b1;
                    end
                    default: halt = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_LUI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ: branch = 1'b1;
            OP_J: jump = 1'b1;
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;   // pc+4 into r31
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: halt = 1'b0;
        endcase
    end

endmodule

// ==== hw/alu_controller.sv ====
`timescale 1ns/1ps

module alu_controller (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    output mips_pkg::alu_op_e alu_op
);
    import mips_pkg::*;

    always_comb begin
        alu_op = ALU_PASS_B;
        if (opcode == OP_RTYPE) begin
            case (funct)
                FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                FN_AND:          alu_op = ALU_AND;
                FN_OR:           alu_op = ALU_OR;
                FN_XOR:          alu_op = ALU_XOR;
                FN_NOR:          alu_op = ALU_NOR;
                FN_SLT:          alu_op = ALU_SLT;
                FN_SLL, FN_SLLV: alu_op = ALU_SLL;
                FN_SRL, FN_SRLV: alu_op = ALU_SRL;
                FN_SRA:          alu_op = ALU_SRA;
                default:         alu_op = ALU_PASS_B;
            endcase
        end else begin
            case (opcode)
                OP_ADDI, OP_ADDIU, OP_LW, OP_SW: alu_op = ALU_ADD; // address calc too
                OP_ANDI: alu_op = ALU_AND;
                OP_ORI:  alu_op = ALU_OR;
                OP_XORI: alu_op = ALU_XOR;
                OP_SLTI: alu_op = ALU_SLT;
                OP_LUI:  alu_op = ALU_LUI;
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ: alu_op = ALU_SUB; // compare
                default: alu_op = ALU_PASS_B;
            endcase
        end
    end

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00, OP_BGEZ = 6'h01, OP_J = 6'h02, OP_JAL = 6'h03,
        OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
        OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c,
        OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f,
        OP_LW = 6'h23, OP_SW = 6'h2b
    } opcode_e;

    // r-type function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_JR = 6'h08, FN_SYSCALL = 6'h0c,
        FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
        FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASS_B   // jumps and anything undecoded
    } alu_op_e;

endpackage
